// File: Makefile
# Verilator build and run for the thread-issue stage

SRCS := $(shell grep -v '^+' vlog.f)

.PHONY: all run clean

all: run

obj_dir/V%: vlog.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $* -Mdir obj_dir

run: obj_dir/Vtb_strand_select
	./obj_dir/Vtb_strand_select | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: rtl/arbiter4.sv
// ============================
// Four-way least-recently-used arbiter. Grant is combinational,
// the order updates on the clock edge after a grant
// ============================

`timescale 1ns/1ps

module arbiter4(
	input			clk,
	input			rst_i,
	input			req0_i,
	input			req1_i,
	input			req2_i,
	input			req3_i,
	input			update_lru_i,
	output logic	grant0_o,
	output logic	grant1_o,
	output logic	grant2_o,
	output logic	grant3_o);

	// Entry 0 is the least recently granted strand
	strand_pkg::strand_id_t		lru_order[4];
	logic [3:0]					req;
	logic [3:0]					grant;
	logic [1:0]					grant_pos;
	logic						grant_valid;

	assign req = {req3_i, req2_i, req1_i, req0_i};

	always_comb
	begin
		grant = '0;
		grant_pos = '0;
		grant_valid = 1'b0;

		// Walk from newest to oldest so the oldest requester wins
		for (int i = 3; i >= 0; i--)
		begin
			if (req[lru_order[i]])
			begin
				grant_pos = 2'(i);
				grant_valid = 1'b1;
			end
		end

		if (grant_valid)
			grant[lru_order[grant_pos]] = 1'b1;
	end

	assign {grant3_o, grant2_o, grant1_o, grant0_o} = grant;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < 4; i++)
				lru_order[i] <= 2'(i);
		end
		else if (update_lru_i && grant_valid)
		begin
			for (int i = 0; i < 3; i++)
			begin
				if (i >= int'(grant_pos))
					lru_order[i] <= lru_order[i + 1];
			end
			lru_order[3] <= lru_order[grant_pos];
		end
	end

endmodule

// File: rtl/execute_hazard_detect.sv
// ============================
// Holds back single-cycle instructions that would reach
// writeback in the same cycle as an earlier long one
// ============================

`timescale 1ns/1ps

module execute_hazard_detect(
	input						clk,
	input						rst_i,
	input strand_pkg::word_t	instruction0_i,
	input strand_pkg::word_t	instruction1_i,
	input strand_pkg::word_t	instruction2_i,
	input strand_pkg::word_t	instruction3_i,
	input						issue0_i,
	input						issue1_i,
	input						issue2_i,
	input						issue3_i,
	output logic				execute_hazard0_o,
	output logic				execute_hazard1_o,
	output logic				execute_hazard2_o,
	output logic				execute_hazard3_o);

	localparam int DEPTH = strand_pkg::LONG_LATENCY - 1;

	logic [DEPTH - 1:0]			long_history;
	logic						long_issued;

	function automatic logic is_long(input strand_pkg::word_t instr);
		is_long = instr[31:29] == strand_pkg::OP_LONG;
	endfunction

	assign long_issued = (issue0_i && is_long(instruction0_i))
		|| (issue1_i && is_long(instruction1_i))
		|| (issue2_i && is_long(instruction2_i))
		|| (issue3_i && is_long(instruction3_i));

	// Bit 0 is last cycle's issue, the top bit the one DEPTH cycles back
	always_ff @(posedge clk)
	begin
		if (rst_i)
			long_history <= '0;
		else
			long_history <= {long_history[DEPTH - 2:0], long_issued};
	end

	assign execute_hazard0_o = long_history[DEPTH - 1] && !is_long(instruction0_i);
	assign execute_hazard1_o = long_history[DEPTH - 1] && !is_long(instruction1_i);
	assign execute_hazard2_o = long_history[DEPTH - 1] && !is_long(instruction2_i);
	assign execute_hazard3_o = long_history[DEPTH - 1] && !is_long(instruction3_i);

endmodule

// File: rtl/strand_fsm.sv
// ============================
// Issue state machine for one strand. Requests issue for the
// fetched instruction and steps strided ones across all lanes
// ============================

`timescale 1ns/1ps

module strand_fsm(
	input							clk,
	input							rst_i,
	input strand_pkg::word_t		instruction_i,
	input							instruction_valid_i,
	input strand_pkg::word_t		pc_i,
	input							flush_i,
	input							suspend_strand_i,
	input							resume_strand_i,
	input strand_pkg::word_t		rollback_strided_offset_i,
	input strand_pkg::lane_t		rollback_reg_lane_i,
	input							grant_i,
	output logic					issue_request_o,
	output logic					next_instruction_o,
	output strand_pkg::word_t		pc_o,
	output strand_pkg::word_t		instruction_o,
	output strand_pkg::lane_t		reg_lane_select_o,
	output strand_pkg::word_t		strided_offset_o);

	strand_pkg::strand_state_t		state;
	strand_pkg::lane_t				lane;
	strand_pkg::word_t				offset;
	strand_pkg::word_t				stride;
	logic							is_strided;
	logic							is_last;
	logic							rolled_back;

	assign is_strided = instruction_i[31:28] == strand_pkg::OP_STRIDED;
	assign stride = {17'd0, instruction_i[14:0]};

	// A normal instruction has a single issue, a strided one ends on lane 0
	assign is_last = !is_strided || lane == 4'd0;

	// Lane or offset differ from a fresh start only after a rollback
	assign rolled_back = lane != strand_pkg::LANE_LAST || offset != '0;

	assign issue_request_o = instruction_valid_i
		&& (state == strand_pkg::ST_READY || state == strand_pkg::ST_STRIDED);
	assign next_instruction_o = grant_i && is_last && !flush_i;

	assign pc_o = pc_i;
	assign instruction_o = instruction_i;
	assign reg_lane_select_o = lane;
	assign strided_offset_o = offset;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state <= strand_pkg::ST_WAIT_INSTR;
			lane <= strand_pkg::LANE_LAST;
			offset <= '0;
		end
		else if (flush_i)
		begin
			state <= strand_pkg::ST_WAIT_INSTR;

			// A strided instruction in flight resumes where the rollback points
			if (is_strided && state != strand_pkg::ST_WAIT_INSTR)
			begin
				lane <= rollback_reg_lane_i;
				offset <= rollback_strided_offset_i;
			end
			else
			begin
				lane <= strand_pkg::LANE_LAST;
				offset <= '0;
			end
		end
		else
		begin
			if (grant_i)
			begin
				if (is_last)
				begin
					state <= strand_pkg::ST_WAIT_INSTR;
					lane <= strand_pkg::LANE_LAST;
					offset <= '0;
				end
				else
				begin
					state <= strand_pkg::ST_STRIDED;
					lane <= lane - 4'd1;
					offset <= offset + stride;
				end
			end
			else if (state == strand_pkg::ST_WAIT_INSTR && instruction_valid_i)
			begin
				if (is_strided && rolled_back)
					state <= strand_pkg::ST_STRIDED;
				else
					state <= strand_pkg::ST_READY;
			end
			else if (state == strand_pkg::ST_SUSPENDED && resume_strand_i)
				state <= strand_pkg::ST_READY;

			// An issue granted in this same cycle still goes out before parking
			if (suspend_strand_i)
				state <= strand_pkg::ST_SUSPENDED;
		end
	end

endmodule

// File: rtl/strand_pkg.sv
// ============================
// Shared widths, opcode classes and the strand state encoding
// for the thread-issue stage. Referenced by scoped name
// ============================

package strand_pkg;

	// Instructions, program counters and strided offsets
	typedef logic [31:0] word_t;

	// Register lane index within a vector register
	typedef logic [3:0] lane_t;

	typedef logic [1:0] strand_id_t;

	localparam int NUM_LANES = 16;
	localparam lane_t LANE_LAST = lane_t'(NUM_LANES - 1);

	// Compared against instruction bits 31..28
	localparam logic [3:0] OP_STRIDED = 4'b1110;

	// Compared against instruction bits 31..29
	localparam logic [2:0] OP_LONG = 3'b110;

	// Execute depth of a long-latency instruction
	localparam int LONG_LATENCY = 4;

	typedef enum logic [1:0] {
		ST_WAIT_INSTR,
		ST_READY,
		ST_STRIDED,
		ST_SUSPENDED
	} strand_state_t;

endpackage

// File: rtl/strand_select_stage.sv
// ============================
// Thread-issue stage. Picks one ready strand per cycle and
// registers its fields onto the issue bus, or a NOP if none
// ============================

`timescale 1ns/1ps

module strand_select_stage(
	input							clk,
	input							rst_i,
	input [3:0]						strand_enable_i,

	input strand_pkg::word_t		instruction0_i,
	input							instruction_valid0_i,
	input strand_pkg::word_t		pc0_i,
	input							flush0_i,
	input							suspend_strand0_i,
	input							resume_strand0_i,
	output logic					next_instruction0_o,
	input strand_pkg::word_t		rollback_strided_offset0_i,
	input strand_pkg::lane_t		rollback_reg_lane0_i,

	input strand_pkg::word_t		instruction1_i,
	input							instruction_valid1_i,
	input strand_pkg::word_t		pc1_i,
	input							flush1_i,
	input							suspend_strand1_i,
	input							resume_strand1_i,
	output logic					next_instruction1_o,
	input strand_pkg::word_t		rollback_strided_offset1_i,
	input strand_pkg::lane_t		rollback_reg_lane1_i,

	input strand_pkg::word_t		instruction2_i,
	input							instruction_valid2_i,
	input strand_pkg::word_t		pc2_i,
	input							flush2_i,
	input							suspend_strand2_i,
	input							resume_strand2_i,
	output logic					next_instruction2_o,
	input strand_pkg::word_t		rollback_strided_offset2_i,
	input strand_pkg::lane_t		rollback_reg_lane2_i,

	input strand_pkg::word_t		instruction3_i,
	input							instruction_valid3_i,
	input strand_pkg::word_t		pc3_i,
	input							flush3_i,
	input							suspend_strand3_i,
	input							resume_strand3_i,
	output logic					next_instruction3_o,
	input strand_pkg::word_t		rollback_strided_offset3_i,
	input strand_pkg::lane_t		rollback_reg_lane3_i,

	output strand_pkg::word_t		pc_o,
	output strand_pkg::word_t		instruction_o,
	output strand_pkg::lane_t		reg_lane_select_o,
	output strand_pkg::word_t		strided_offset_o,
	output strand_pkg::strand_id_t	strand_id_o,
	output strand_pkg::word_t		idle_cycle_count_o);

	strand_pkg::word_t		pc[4];
	strand_pkg::word_t		instruction[4];
	strand_pkg::lane_t		reg_lane_select[4];
	strand_pkg::word_t		strided_offset[4];
	logic [3:0]				strand_ready;
	logic [3:0]				issue_strand;
	logic [3:0]				execute_hazard;
	logic [3:0]				arb_req;

	strand_fsm s0(.clk(clk), .rst_i(rst_i), .instruction_i(instruction0_i),
		.instruction_valid_i(instruction_valid0_i), .pc_i(pc0_i), .flush_i(flush0_i),
		.suspend_strand_i(suspend_strand0_i), .resume_strand_i(resume_strand0_i),
		.rollback_strided_offset_i(rollback_strided_offset0_i),
		.rollback_reg_lane_i(rollback_reg_lane0_i), .grant_i(issue_strand[0]),
		.issue_request_o(strand_ready[0]), .next_instruction_o(next_instruction0_o),
		.pc_o(pc[0]), .instruction_o(instruction[0]),
		.reg_lane_select_o(reg_lane_select[0]), .strided_offset_o(strided_offset[0]));

	strand_fsm s1(.clk(clk), .rst_i(rst_i), .instruction_i(instruction1_i),
		.instruction_valid_i(instruction_valid1_i), .pc_i(pc1_i), .flush_i(flush1_i),
		.suspend_strand_i(suspend_strand1_i), .resume_strand_i(resume_strand1_i),
		.rollback_strided_offset_i(rollback_strided_offset1_i),
		.rollback_reg_lane_i(rollback_reg_lane1_i), .grant_i(issue_strand[1]),
		.issue_request_o(strand_ready[1]), .next_instruction_o(next_instruction1_o),
		.pc_o(pc[1]), .instruction_o(instruction[1]),
		.reg_lane_select_o(reg_lane_select[1]), .strided_offset_o(strided_offset[1]));

	strand_fsm s2(.clk(clk), .rst_i(rst_i), .instruction_i(instruction2_i),
		.instruction_valid_i(instruction_valid2_i), .pc_i(pc2_i), .flush_i(flush2_i),
		.suspend_strand_i(suspend_strand2_i), .resume_strand_i(resume_strand2_i),
		.rollback_strided_offset_i(rollback_strided_offset2_i),
		.rollback_reg_lane_i(rollback_reg_lane2_i), .grant_i(issue_strand[2]),
		.issue_request_o(strand_ready[2]), .next_instruction_o(next_instruction2_o),
		.pc_o(pc[2]), .instruction_o(instruction[2]),
		.reg_lane_select_o(reg_lane_select[2]), .strided_offset_o(strided_offset[2]));

	strand_fsm s3(.clk(clk), .rst_i(rst_i), .instruction_i(instruction3_i),
		.instruction_valid_i(instruction_valid3_i), .pc_i(pc3_i), .flush_i(flush3_i),
		.suspend_strand_i(suspend_strand3_i), .resume_strand_i(resume_strand3_i),
		.rollback_strided_offset_i(rollback_strided_offset3_i),
		.rollback_reg_lane_i(rollback_reg_lane3_i), .grant_i(issue_strand[3]),
		.issue_request_o(strand_ready[3]), .next_instruction_o(next_instruction3_o),
		.pc_o(pc[3]), .instruction_o(instruction[3]),
		.reg_lane_select_o(reg_lane_select[3]), .strided_offset_o(strided_offset[3]));

	execute_hazard_detect ehd(.clk(clk), .rst_i(rst_i),
		.instruction0_i(instruction[0]), .instruction1_i(instruction[1]),
		.instruction2_i(instruction[2]), .instruction3_i(instruction[3]),
		.issue0_i(issue_strand[0]), .issue1_i(issue_strand[1]),
		.issue2_i(issue_strand[2]), .issue3_i(issue_strand[3]),
		.execute_hazard0_o(execute_hazard[0]), .execute_hazard1_o(execute_hazard[1]),
		.execute_hazard2_o(execute_hazard[2]), .execute_hazard3_o(execute_hazard[3]));

	// Disabled or hazarded strands never reach the arbiter
	assign arb_req = strand_ready & strand_enable_i & ~execute_hazard;

	arbiter4 issue_arb(.clk(clk), .rst_i(rst_i),
		.req0_i(arb_req[0]), .req1_i(arb_req[1]), .req2_i(arb_req[2]), .req3_i(arb_req[3]),
		.update_lru_i(1'b1),
		.grant0_o(issue_strand[0]), .grant1_o(issue_strand[1]),
		.grant2_o(issue_strand[2]), .grant3_o(issue_strand[3]));

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			pc_o <= '0;
			instruction_o <= '0;
			reg_lane_select_o <= '0;
			strided_offset_o <= '0;
			strand_id_o <= '0;
			idle_cycle_count_o <= '0;
		end
		else if (issue_strand == 4'd0)
		begin
			// Nothing granted, so a NOP goes out and counts as idle
			pc_o <= '0;
			instruction_o <= '0;
			reg_lane_select_o <= '0;
			strided_offset_o <= '0;
			strand_id_o <= '0;
			idle_cycle_count_o <= idle_cycle_count_o + 32'd1;
		end
		else
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (issue_strand[i])
				begin
					pc_o <= pc[i];
					instruction_o <= instruction[i];
					reg_lane_select_o <= reg_lane_select[i];
					strided_offset_o <= strided_offset[i];
					strand_id_o <= 2'(i);
				end
			end
		end
	end

endmodule

// File: testbench/tb_strand_select.sv
// ============================
// Testbench for the thread-issue stage. Fetch models feed each
// strand and every bus cycle is checked against expected issues
// ============================

`timescale 1ns/1ps

module tb_strand_select;

	typedef struct packed {
		strand_pkg::word_t	pc;
		strand_pkg::word_t	instr;
		strand_pkg::lane_t	lane;
		strand_pkg::word_t	offset;
	} issue_rec_t;

	logic					clk;
	logic					rst_i;
	logic [3:0]				strand_enable_i;
	strand_pkg::word_t		instr[4] = '{default: '0};
	strand_pkg::word_t		pc[4] = '{default: '0};
	logic [3:0]				valid = '0;
	logic [3:0]				flush;
	logic [3:0]				suspend;
	logic [3:0]				resume;
	strand_pkg::word_t		rb_offset[4];
	strand_pkg::lane_t		rb_lane[4];
	logic [3:0]				next_instr;
	strand_pkg::word_t		pc_o;
	strand_pkg::word_t		instruction_o;
	strand_pkg::lane_t		reg_lane_select_o;
	strand_pkg::word_t		strided_offset_o;
	strand_pkg::strand_id_t	strand_id_o;
	strand_pkg::word_t		idle_cycle_count_o;

	issue_rec_t				exp_q[4][$];
	strand_pkg::word_t		fetch_instr[4][$];
	strand_pkg::word_t		fetch_pc[4][$];
	strand_pkg::word_t		pc_next[4];
	int						loaded[4];
	int						released_count[4];
	int						last_issue[4];
	logic [3:0]				released = '0;
	logic [3:0]				prev_enable;
	logic [3:0]				silent;
	logic [2:0]				long_hist;
	logic					armed;
	logic					fairness_on;
	int						errors;
	int						nops;
	int						cycle;
	logic [31:0]			lcg_state;

	strand_select_stage DUT(.clk(clk), .rst_i(rst_i), .strand_enable_i(strand_enable_i),
		.instruction0_i(instr[0]), .instruction_valid0_i(valid[0]), .pc0_i(pc[0]),
		.flush0_i(flush[0]), .suspend_strand0_i(suspend[0]), .resume_strand0_i(resume[0]),
		.next_instruction0_o(next_instr[0]), .rollback_strided_offset0_i(rb_offset[0]),
		.rollback_reg_lane0_i(rb_lane[0]),
		.instruction1_i(instr[1]), .instruction_valid1_i(valid[1]), .pc1_i(pc[1]),
		.flush1_i(flush[1]), .suspend_strand1_i(suspend[1]), .resume_strand1_i(resume[1]),
		.next_instruction1_o(next_instr[1]), .rollback_strided_offset1_i(rb_offset[1]),
		.rollback_reg_lane1_i(rb_lane[1]),
		.instruction2_i(instr[2]), .instruction_valid2_i(valid[2]), .pc2_i(pc[2]),
		.flush2_i(flush[2]), .suspend_strand2_i(suspend[2]), .resume_strand2_i(resume[2]),
		.next_instruction2_o(next_instr[2]), .rollback_strided_offset2_i(rb_offset[2]),
		.rollback_reg_lane2_i(rb_lane[2]),
		.instruction3_i(instr[3]), .instruction_valid3_i(valid[3]), .pc3_i(pc[3]),
		.flush3_i(flush[3]), .suspend_strand3_i(suspend[3]), .resume_strand3_i(resume[3]),
		.next_instruction3_o(next_instr[3]), .rollback_strided_offset3_i(rb_offset[3]),
		.rollback_reg_lane3_i(rb_lane[3]),
		.pc_o(pc_o), .instruction_o(instruction_o), .reg_lane_select_o(reg_lane_select_o),
		.strided_offset_o(strided_offset_o), .strand_id_o(strand_id_o),
		.idle_cycle_count_o(idle_cycle_count_o));

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int issue_count(input strand_pkg::word_t ins,
		input strand_pkg::lane_t start_lane);
		if (ins[31:28] == strand_pkg::OP_STRIDED)
			return int'(start_lane) + 1;
		return 1;
	endfunction

	// Issue k of an instruction, counted from the lane where its sequence starts
	function automatic issue_rec_t expected_issue(input strand_pkg::word_t p,
		input strand_pkg::word_t ins, input strand_pkg::lane_t start_lane,
		input strand_pkg::word_t start_offset, input int k);
		issue_rec_t r;
		strand_pkg::word_t stride;
		stride = {17'd0, ins[14:0]};
		r.pc = p;
		r.instr = ins;
		r.lane = 4'd15;
		r.offset = '0;
		if (ins[31:28] == strand_pkg::OP_STRIDED)
		begin
			r.lane = start_lane - 4'(k);
			r.offset = start_offset + stride * 32'(k);
		end
		return r;
	endfunction

	function automatic logic all_drained(input logic [3:0] mask);
		logic done;
		done = 1'b1;
		for (int n = 0; n < 4; n++)
			if (mask[n] && (exp_q[n].size() != 0 || fetch_instr[n].size() != 0))
				done = 1'b0;
		return done;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("** Error: %s is %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	// Kind 0 is single-cycle, 1 is long, anything else strided
	task automatic load(input int n, input int kind);
		strand_pkg::word_t ins;
		lcg_state = lcg_next(lcg_state);
		case (kind)
			0: ins = {4'b0001, lcg_state[27:0]};
			1: ins = {3'b110, lcg_state[28:0]};
			default: ins = {4'b1110, lcg_state[27:15], 5'd0, lcg_state[9:0]};
		endcase
		fetch_instr[n].push_back(ins);
		fetch_pc[n].push_back(pc_next[n]);
		for (int k = 0; k < issue_count(ins, 4'd15); k++)
			exp_q[n].push_back(expected_issue(pc_next[n], ins, 4'd15, '0, k));
		pc_next[n] += 32'd4;
		loaded[n]++;
	endtask

	task automatic wait_drained(input logic [3:0] mask);
		int i;
		i = 0;
		while (!all_drained(mask) && i < 3000)
		begin
			@(posedge clk);
			i++;
		end
		if (!all_drained(mask))
		begin
			$display("Timeout: strands %b did not finish their instructions", mask);
			errors++;
		end
	endtask

	task automatic wait_issues_left(input int n, input int left);
		int i;
		i = 0;
		while (exp_q[n].size() > left && i < 500)
		begin
			@(posedge clk);
			i++;
		end
		if (exp_q[n].size() > left)
		begin
			$display("Timeout: strand %0d stopped issuing", n);
			errors++;
		end
	endtask

	task automatic park_strand(input int n);
		@(posedge clk);
		suspend[n] <= 1'b1;
		@(posedge clk);
		suspend[n] <= 1'b0;
		@(posedge clk);
		silent[n] = 1'b1;
		repeat (8) @(posedge clk);
	endtask

	// The fetch model samples the release pulse mid-cycle and acts on it at the edge
	always @(negedge clk)
	begin
		released = rst_i ? 4'd0 : next_instr;
		for (int n = 0; n < 4; n++)
			if (released[n])
				released_count[n]++;
	end

	always @(posedge clk)
	begin
		for (int n = 0; n < 4; n++)
		begin
			if (released[n])
			begin
				void'(fetch_instr[n].pop_front());
				void'(fetch_pc[n].pop_front());
			end
			valid[n] <= fetch_instr[n].size() != 0;
			instr[n] <= fetch_instr[n].size() != 0 ? fetch_instr[n][0] : '0;
			pc[n] <= fetch_pc[n].size() != 0 ? fetch_pc[n][0] : '0;
		end
	end

	// The bus seen at each falling edge holds the grant of the previous cycle
	always @(negedge clk)
	begin
		issue_rec_t rec;
		int id;
		logic long_now;
		if (rst_i || !armed)
			armed = !rst_i;
		else
		begin
			cycle++;
			id = int'(strand_id_o);
			long_now = pc_o != 0 && instruction_o[31:29] == strand_pkg::OP_LONG;
			if (pc_o == 0)
			begin
				nops++;
				check_value("instruction_o", instruction_o, '0);
				check_value("reg_lane_select_o", reg_lane_select_o, '0);
				check_value("strided_offset_o", strided_offset_o, '0);
				check_value("strand_id_o", strand_id_o, '0);
			end
			else
			begin
				if (!prev_enable[id] || silent[id])
				begin
					$display("Strand %0d issued while disabled or suspended", id);
					errors++;
				end
				if (!long_now && long_hist[2])
				begin
					$display("Single-cycle issue three cycles after a long one");
					errors++;
				end
				if (fairness_on && reg_lane_select_o != 4'd15 && cycle - last_issue[id] > 4)
				begin
					$display("Strand %0d waited %0d slots", id, cycle - last_issue[id]);
					errors++;
				end
				last_issue[id] = cycle;
				if (exp_q[id].size() == 0)
				begin
					$display("Strand %0d issued with nothing expected", id);
					errors++;
				end
				else
				begin
					rec = exp_q[id].pop_front();
					check_value("pc_o", pc_o, rec.pc);
					check_value("instruction_o", instruction_o, rec.instr);
					check_value("reg_lane_select_o", reg_lane_select_o, rec.lane);
					check_value("strided_offset_o", strided_offset_o, rec.offset);
				end
			end
			check_value("idle_cycle_count_o", idle_cycle_count_o, nops);
			long_hist = {long_hist[1:0], long_now};
		end
		prev_enable = strand_enable_i;
	end

	initial
	begin
		clk = 1'b0;
		rst_i <= 1'b1;
		strand_enable_i <= 4'hf;
		flush <= '0;
		suspend <= '0;
		resume <= '0;
		silent = '0;
		long_hist = '0;
		armed = 1'b0;
		fairness_on = 1'b0;
		errors = 0;
		nops = 0;
		cycle = 0;
		lcg_state = 32'd29;
		for (int n = 0; n < 4; n++)
		begin
			rb_offset[n] <= '0;
			rb_lane[n] <= '0;
			pc_next[n] = 32'h1000 * (n + 1);
			loaded[n] = 0;
			released_count[n] = 0;
			last_issue[n] = 0;
		end
		repeat (5) @(posedge clk);
		rst_i <= 1'b0;

		// Mixed single-cycle and long instructions on every strand
		for (int i = 0; i < 6; i++)
			for (int n = 0; n < 4; n++)
			begin
				lcg_state = lcg_next(lcg_state);
				load(n, int'(lcg_state[20]));
			end
		wait_drained(4'hf);
		repeat (5) @(posedge clk);

		// Four strided instructions compete for every slot
		fairness_on = 1'b1;
		for (int n = 0; n < 4; n++)
			load(n, 2);
		wait_drained(4'hf);
		fairness_on = 1'b0;

		@(posedge clk);
		strand_enable_i <= 4'b0111;
		for (int n = 0; n < 4; n++)
		begin
			load(n, 0);
			load(n, 1);
		end
		wait_drained(4'b0111);
		repeat (10) @(posedge clk);
		strand_enable_i <= 4'hf;
		wait_drained(4'hf);

		load(0, 2);
		wait_issues_left(0, 10);
		park_strand(0);
		silent[0] = 1'b0;
		resume[0] <= 1'b1;
		@(posedge clk);
		resume[0] <= 1'b0;
		wait_drained(4'hf);

		// Rollback to lane 5 while the strand is parked
		load(1, 2);
		wait_issues_left(1, 10);
		park_strand(1);
		exp_q[1].delete();
		for (int k = 0; k < 6; k++)
			exp_q[1].push_back(expected_issue(fetch_pc[1][0], fetch_instr[1][0], 4'd5,
				32'h300, k));
		silent[1] = 1'b0;
		flush[1] <= 1'b1;
		rb_lane[1] <= 4'd5;
		rb_offset[1] <= 32'h300;
		@(posedge clk);
		flush[1] <= 1'b0;
		wait_drained(4'hf);

		repeat (5) @(posedge clk);
		for (int n = 0; n < 4; n++)
			check_value("next_instruction pulses", released_count[n], loaded[n]);
		$display("Finished after %0d cycles with %0d errors", cycle, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: vlog.f
rtl/strand_pkg.sv
rtl/strand_fsm.sv
rtl/execute_hazard_detect.sv
rtl/arbiter4.sv
rtl/strand_select_stage.sv
testbench/tb_strand_select.sv
